/* hdl/icache.sv */
// direct-mapped instruction cache
// registered lookup, line refill through the memory controller
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module icache (
  input  wire                         clk_in,
  input  wire                         rst_in,
  input  wire                         rdy_in,
  input  wire                         fetch_en,
  input  wire mem_types_pkg::addr_t   fetch_addr,
  output logic                        fetch_valid,
  output mem_types_pkg::word_t        fetch_inst,
  output logic                        refill_en,
  output mem_req_pkg::refill_req_t    refill_req,
  input  wire                         refill_done,
  input  wire mem_types_pkg::block_t  refill_block
);

  import mem_types_pkg::*;
  import mem_req_pkg::*;

  localparam int word_w = $bits(word_t);
  localparam int off_lo = 2;                            // bits below are the byte in a word
  localparam int idx_lo = off_lo + `MEM_BLOCK_WIDTH;
  localparam int tag_lo = `MEM_ADDR_WIDTH - $bits(tag_t); // overlaps the top index bits
  localparam int blocks = 1 << `MEM_CACHE_WIDTH;

  typedef logic [`MEM_BLOCK_WIDTH-1:0] off_t;

  tag_t   tag_arr [blocks];
  block_t data_arr [blocks];
  logic [blocks-1:0] valid_arr;

  cache_state_e state;
  logic         valid_q;      // answer pending for the client
  addr_t        pend_addr;    // fetch that missed

  tag_t   f_tag;
  index_t f_index;
  off_t   f_off;
  tag_t   p_tag;
  index_t p_index;
  off_t   p_off;
  block_t hit_block;
  logic   hit;
  logic   accept;

  // split the live fetch address and the latched miss address
  assign f_tag   = fetch_addr[`MEM_ADDR_WIDTH-1:tag_lo];
  assign f_index = fetch_addr[idx_lo +: $bits(index_t)];
  assign f_off   = fetch_addr[off_lo +: `MEM_BLOCK_WIDTH];
  assign p_tag   = pend_addr[`MEM_ADDR_WIDTH-1:tag_lo];
  assign p_index = pend_addr[idx_lo +: $bits(index_t)];
  assign p_off   = pend_addr[off_lo +: `MEM_BLOCK_WIDTH];

  assign hit_block = data_arr[f_index];
  assign hit       = valid_arr[f_index] && (tag_arr[f_index] == f_tag);

  // the enable is still high during the answer cycle, so skip that one
  assign accept = fetch_en && !valid_q && (state == cs_lookup);

  assign refill_en   = (state == cs_refill);
  assign refill_req  = '{addr: {pend_addr[`MEM_ADDR_WIDTH-1:idx_lo], {idx_lo{1'b0}}}};
  assign fetch_valid = valid_q && rdy_in;  // pulse waits out a pause

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state     <= cs_lookup;
      valid_q   <= 1'b0;
      valid_arr <= '0;
    end else if (rdy_in) begin
      valid_q <= 1'b0;
      case (state)
        cs_lookup: begin
          if (accept) begin
            if (hit) begin
              valid_q <= 1'b1;
            end else begin
              state <= cs_refill;
            end
          end
        end
        default: begin
          if (refill_done) begin
            valid_arr[p_index] <= 1'b1;
            valid_q            <= 1'b1;   // answer together with the line write
            state              <= cs_lookup;
          end
        end
      endcase
    end
  end

  // line storage and returned instruction
  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      if (accept) begin
        pend_addr  <= fetch_addr;
        fetch_inst <= hit_block[f_off * word_w +: word_w];
      end
      if (state == cs_refill && refill_done) begin
        tag_arr[p_index]  <= p_tag;
        data_arr[p_index] <= refill_block;
        fetch_inst        <= refill_block[p_off * word_w +: word_w];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/mem_config.svh */
// cache geometry, RAM size, I/O address and bus widths
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// cache geometry
`define MEM_BLOCK_WIDTH 1      // log2 instructions per block
`define MEM_CACHE_WIDTH 8      // log2 block count

// bus widths
`define MEM_ADDR_WIDTH 32
`define MEM_WORD_WIDTH 32
`define MEM_BYTE_WIDTH 8

// RAM behind the byte bus, 128 KB
`define MEM_RAM_BYTES 131072

// UART data port, mapped where address bits 17 and 16 are both set
`define MEM_IO_ADDR 32'h0003_0000
`define MEM_IO_SEL_HI 17
`define MEM_IO_SEL_LO 16

`endif

/* hdl/mem_ctrl.sv */
// byte bus controller: arbiter between cache refill and load/store,
// beat sequencer, read assembly, store beats and UART back-pressure
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_ctrl (
  input  wire                           clk_in,
  input  wire                           rst_in,
  input  wire                           rdy_in,
  input  wire                           refill_en,
  input  wire mem_req_pkg::refill_req_t refill_req,
  output logic                          refill_done,
  output mem_types_pkg::block_t         refill_block,
  input  wire                           ls_en,
  input  wire mem_req_pkg::ls_req_t     ls_req,
  output logic                          ls_done,
  output mem_types_pkg::word_t          ls_rdata,
  input  wire mem_types_pkg::byte_t     mem_din,
  output mem_types_pkg::byte_t          mem_dout,
  output mem_types_pkg::addr_t          mem_a,
  output logic                          mem_wr,
  input  wire                           io_buffer_full
);

  import mem_types_pkg::*;
  import mem_req_pkg::*;

  localparam int blk_w        = $bits(block_t);
  localparam int byte_w       = $bits(byte_t);
  localparam int refill_beats = blk_w / byte_w;
  localparam int cnt_w        = $clog2(refill_beats + 1);

  typedef logic [cnt_w-1:0] cnt_t;

  ctrl_state_e state;
  client_e     last_served;   // also the client currently on the bus
  cnt_t        beat_left;     // addresses still to issue
  cnt_t        recv_left;     // read bytes still to come back
  cnt_t        recv_next;
  cnt_t        width_beats;
  logic        byte_live;     // mem_din carries a requested byte
  logic        read_issue;
  logic        io_stall;
  logic        ls_want;
  logic        ic_want;
  logic        grant_ic;
  logic        grant_ls;
  logic        refill_done_q;
  logic        ls_done_q;
  ls_width_e   rd_width;
  word_t       wr_data;       // store data, low byte goes out next
  block_t      asm_q;         // read assembly, newest byte on top

  always_comb begin
    case (ls_req.width)
      width_byte: width_beats = cnt_t'(1);
      width_half: width_beats = cnt_t'(2);
      default:    width_beats = cnt_t'(4);
    endcase
  end

  // a client in its done cycle still holds its enable
  assign ls_want  = ls_en && !ls_done_q;
  assign ic_want  = refill_en && !refill_done_q;
  assign grant_ic = ic_want && (!ls_want || last_served == client_ls);
  assign grant_ls = ls_want && !grant_ic;

  assign io_stall   = mem_a[`MEM_IO_SEL_HI] && mem_a[`MEM_IO_SEL_LO] && io_buffer_full;
  assign mem_wr     = rdy_in && (state == st_write) && !io_stall;
  assign read_issue = rdy_in && (state == st_read) && (beat_left != '0);
  assign recv_next  = byte_live ? recv_left - cnt_t'(1) : recv_left;
  assign mem_dout   = wr_data[byte_w-1:0];

  assign refill_block = asm_q;
  assign refill_done  = refill_done_q && rdy_in;
  assign ls_done      = ls_done_q && rdy_in;

  // loaded bytes end up in the top of the assembly register
  always_comb begin
    case (rd_width)
      width_byte: ls_rdata = word_t'(asm_q[blk_w-1 -: byte_w]);
      width_half: ls_rdata = word_t'(asm_q[blk_w-1 -: 2*byte_w]);
      default:    ls_rdata = asm_q[blk_w-1 -: $bits(word_t)];
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state         <= st_idle;
      last_served   <= client_ls;   // cache wins the first tie
      mem_a         <= '0;
      beat_left     <= '0;
      recv_left     <= '0;
      byte_live     <= 1'b0;
      refill_done_q <= 1'b0;
      ls_done_q     <= 1'b0;
    end else begin
      // RAM answers even during a pause, so this side ignores rdy_in
      byte_live <= read_issue;
      if (byte_live) begin
        recv_left <= recv_left - cnt_t'(1);
      end

      if (rdy_in) begin
        refill_done_q <= 1'b0;
        ls_done_q     <= 1'b0;
        case (state)
          st_read: begin
            if (beat_left != '0) begin
              mem_a     <= mem_a + addr_t'(1);
              beat_left <= beat_left - cnt_t'(1);
            end
            if (recv_next == '0) begin   // last byte is in
              state <= st_idle;
              if (last_served == client_icache) begin
                refill_done_q <= 1'b1;
              end else begin
                ls_done_q <= 1'b1;
              end
            end
          end
          st_write: begin
            if (mem_wr) begin
              mem_a     <= mem_a + addr_t'(1);
              beat_left <= beat_left - cnt_t'(1);
              if (beat_left == cnt_t'(1)) begin
                state     <= st_idle;
                ls_done_q <= 1'b1;
              end
            end
          end
          default: begin
            if (grant_ic) begin
              mem_a       <= refill_req.addr;
              beat_left   <= cnt_t'(refill_beats);
              recv_left   <= cnt_t'(refill_beats);
              last_served <= client_icache;
              state       <= st_read;
            end else if (grant_ls) begin
              mem_a       <= ls_req.addr;
              beat_left   <= width_beats;
              recv_left   <= width_beats;
              last_served <= client_ls;
              state       <= ls_req.wr ? st_write : st_read;
            end
          end
        endcase
      end
    end
  end

  // payload, no reset
  always_ff @(posedge clk_in) begin
    if (byte_live) begin
      asm_q <= {mem_din, asm_q[blk_w-1:byte_w]};  // little endian shift in
    end
    if (rdy_in && state == st_idle && grant_ls) begin
      rd_width <= ls_req.width;
      wr_data  <= ls_req.wdata;
    end else if (mem_wr) begin
      wr_data <= wr_data >> byte_w;
    end
  end

endmodule

`default_nettype wire

/* hdl/mem_req_pkg.sv */
// request structs, access width and FSM state encodings
`default_nettype none

package mem_req_pkg;

  import mem_types_pkg::*;

  typedef enum logic [1:0] {
    width_byte = 2'd0,
    width_half = 2'd1,
    width_word = 2'd2
  } ls_width_e;

  // load/store request, held by the client until ls_done
  typedef struct packed {
    logic      wr;     // 1 for store
    ls_width_e width;
    addr_t     addr;
    word_t     wdata;
  } ls_req_t;

  typedef struct packed {
    addr_t addr;  // block aligned
  } refill_req_t;

  // last-served flag of the bus arbiter
  typedef enum logic {
    client_ls     = 1'b0,
    client_icache = 1'b1
  } client_e;

  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_read  = 2'd1,
    st_write = 2'd2
  } ctrl_state_e;

  typedef enum logic {
    cs_lookup = 1'b0,
    cs_refill = 1'b1
  } cache_state_e;

endpackage

`default_nettype wire

/* hdl/mem_subsystem.sv */
// memory subsystem top: instruction cache plus byte bus controller
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
  input  wire                          clk_in,
  input  wire                          rst_in,
  input  wire                          rdy_in,
  input  wire                          fetch_en,
  input  wire mem_types_pkg::addr_t    fetch_addr,
  output logic                         fetch_valid,
  output mem_types_pkg::word_t         fetch_inst,
  input  wire                          ls_en,
  input  wire mem_req_pkg::ls_req_t    ls_req,
  output logic                         ls_done,
  output mem_types_pkg::word_t         ls_rdata,
  input  wire mem_types_pkg::byte_t    mem_din,
  output mem_types_pkg::byte_t         mem_dout,
  output mem_types_pkg::addr_t         mem_a,
  output logic                         mem_wr,
  input  wire                          io_buffer_full
);

  import mem_types_pkg::*;
  import mem_req_pkg::*;

  // cache refill port
  logic        refill_en;
  refill_req_t refill_req;
  logic        refill_done;
  block_t      refill_block;

  icache inst_cache (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rdy_in       (rdy_in),
    .fetch_en     (fetch_en),
    .fetch_addr   (fetch_addr),
    .fetch_valid  (fetch_valid),
    .fetch_inst   (fetch_inst),
    .refill_en    (refill_en),
    .refill_req   (refill_req),
    .refill_done  (refill_done),
    .refill_block (refill_block)
  );

  // load/store port goes straight to the bus owner
  mem_ctrl bus_ctrl (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .refill_en      (refill_en),
    .refill_req     (refill_req),
    .refill_done    (refill_done),
    .refill_block   (refill_block),
    .ls_en          (ls_en),
    .ls_req         (ls_req),
    .ls_done        (ls_done),
    .ls_rdata       (ls_rdata),
    .mem_din        (mem_din),
    .mem_dout       (mem_dout),
    .mem_a          (mem_a),
    .mem_wr         (mem_wr),
    .io_buffer_full (io_buffer_full)
  );

endmodule

`default_nettype wire

/* hdl/mem_types_pkg.sv */
// plain vector types for addresses, data and cache fields
`default_nettype none

`include "mem_config.svh"

package mem_types_pkg;

  typedef logic [`MEM_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`MEM_WORD_WIDTH-1:0] word_t;
  typedef logic [`MEM_BYTE_WIDTH-1:0] byte_t;

  // one cache line, instruction 0 in the low word
  typedef logic [`MEM_WORD_WIDTH*(1 << `MEM_BLOCK_WIDTH)-1:0] block_t;

  // address bits above index and block offset
  typedef logic [`MEM_ADDR_WIDTH-`MEM_CACHE_WIDTH-`MEM_BLOCK_WIDTH-1:0] tag_t;

  typedef logic [`MEM_CACHE_WIDTH-1:0] index_t;  // cache line number

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_mem_subsystem \
  -Mdir obj_dir -o sim_mem \
  && ./obj_dir/sim_mem +verilator+error+limit+1000 2>&1 | tee sim.log \
  || echo "build or run failed"

grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0

/* sim/mem_scoreboard.sv */
// scoreboard with shadow memory image, predicted fetch and load data,
// store beat checks and error counts
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_scoreboard (
  input wire                       clk_in,
  input wire                       rst_in,
  input wire                       fetch_valid,
  input wire mem_types_pkg::addr_t fetch_addr,
  input wire mem_types_pkg::word_t fetch_inst,
  input wire                       ls_en,
  input wire                       ls_done,
  input wire mem_req_pkg::ls_req_t ls_req,
  input wire mem_types_pkg::word_t ls_rdata,
  input wire                       mem_wr,
  input wire mem_types_pkg::addr_t mem_a,
  input wire mem_types_pkg::byte_t mem_dout
);

  import mem_types_pkg::*;
  import mem_req_pkg::*;

  byte_t shadow [0:`MEM_RAM_BYTES-1];  // filled by the testbench
  int    errors = 0;
  int    passes = 0;

  function automatic int unsigned width_bytes(input ls_width_e w);
    case (w)
      width_byte: return 1;
      width_half: return 2;
      default:    return 4;
    endcase
  endfunction

  // little endian, zero extended
  function automatic word_t read_shadow(input addr_t a, input int unsigned n);
    word_t v;
    addr_t p;
    v = '0;
    for (int unsigned k = 0; k < n; k++) begin
      p = a + addr_t'(k);
      v[8*k +: 8] = shadow[p[16:0]];
    end
    return v;
  endfunction

  task automatic compare(input string what, input addr_t a, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s addr %h got %h expected %h", $time, what, a, got, exp);
      errors++;
    end else begin
      passes++;
    end
  endtask

  // outputs are settled at mid-cycle
  always @(negedge clk_in) begin
    addr_t off;
    if (!rst_in) begin
      if (fetch_valid) begin
        compare("fetch", fetch_addr, fetch_inst, read_shadow(fetch_addr, 4));
      end
      // each write beat carries its byte of the held store
      if (mem_wr) begin
        off = mem_a - ls_req.addr;
        if (!(ls_en && ls_req.wr) || off >= addr_t'(width_bytes(ls_req.width))) begin
          $display("mismatch at %0t: write beat at %h outside the store at %h",
                   $time, mem_a, ls_req.addr);
          errors++;
        end else begin
          compare("store beat", mem_a, word_t'(mem_dout),
                  word_t'(ls_req.wdata[8*off[1:0] +: 8]));
        end
      end
      if (ls_done && ls_req.wr) begin
        for (int unsigned k = 0; k < width_bytes(ls_req.width); k++) begin
          if ((ls_req.addr + addr_t'(k)) < addr_t'(`MEM_RAM_BYTES)) begin
            shadow[ls_req.addr[16:0] + 17'(k)] = ls_req.wdata[8*k +: 8];  // UART bytes skipped
          end
        end
      end else if (ls_done) begin
        compare("load", ls_req.addr, ls_rdata,
                read_shadow(ls_req.addr, width_bytes(ls_req.width)));
      end
    end
  end

endmodule

`default_nettype wire

/* sim/mem_subsystem_chk.sv */
// bus and pulse protocol assertions, bound into the memory subsystem top
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_subsystem_chk (
  input wire                       clk_in,
  input wire                       rst_in,
  input wire                       rdy_in,
  input wire                       fetch_valid,
  input wire                       ls_done,
  input wire                       mem_wr,
  input wire                       io_buffer_full,
  input wire mem_types_pkg::addr_t mem_a
);

  int  err_io  = 0;
  int  err_rdy = 0;
  int  err_fv  = 0;
  int  err_ld  = 0;
  wire io_sel  = mem_a[`MEM_IO_SEL_HI] && mem_a[`MEM_IO_SEL_LO];

  // UART beat must wait for room in the buffer
  io_hold: assert property (@(posedge clk_in) disable iff (rst_in)
    !(mem_wr && io_sel && io_buffer_full))
    else begin $error("UART write beat issued while buffer full"); err_io++; end

  // no completion during a pause
  pause_quiet: assert property (@(posedge clk_in) disable iff (rst_in)
    !((fetch_valid || ls_done) && !rdy_in))
    else begin $error("done pulse while rdy_in low"); err_rdy++; end

  fv_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
    fetch_valid |=> !fetch_valid)
    else begin $error("fetch_valid wider than one cycle"); err_fv++; end

  ld_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
    ls_done |=> !ls_done)
    else begin $error("ls_done wider than one cycle"); err_ld++; end

endmodule

bind mem_subsystem mem_subsystem_chk chk (
  .clk_in         (clk_in),
  .rst_in         (rst_in),
  .rdy_in         (rdy_in),
  .fetch_valid    (fetch_valid),
  .ls_done        (ls_done),
  .mem_wr         (mem_wr),
  .io_buffer_full (io_buffer_full),
  .mem_a          (mem_a)
);

`default_nettype wire

/* sim/tb_mem_subsystem.sv */
// memory subsystem testbench with clock, reset, RAM model,
// random fetch and load/store traffic, pauses, UART back-pressure, watchdog
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module tb_mem_subsystem;

  import mem_types_pkg::*;
  import mem_req_pkg::*;

  localparam int unsigned n_req   = 40 + 40 + 60 + 40 + 40 + 20;
  localparam int unsigned timeout = n_req * 40 + 1000;

  logic    clk_in = 1'b0;
  logic    rst_in = 1'b1;
  logic    rdy_in = 1'b1;
  logic    fetch_en = 1'b0;
  addr_t   fetch_addr = '0;
  logic    ls_en = 1'b0;
  ls_req_t ls_req = '0;
  byte_t   mem_din = '0;
  logic    io_buffer_full = 1'b0;
  logic    fetch_valid;
  word_t   fetch_inst;
  logic    ls_done;
  word_t   ls_rdata;
  byte_t   mem_dout;
  addr_t   mem_a;
  logic    mem_wr;

  byte_t       ram [0:`MEM_RAM_BYTES-1];
  logic        pause_on = 1'b0;
  logic        io_on = 1'b0;
  int unsigned pause_left = 0;
  int          tb_errs = 0;

  mem_subsystem uut (.*);

  mem_scoreboard scoreboard (
    .clk_in(clk_in), .rst_in(rst_in), .fetch_valid(fetch_valid), .fetch_addr(fetch_addr),
    .fetch_inst(fetch_inst), .ls_en(ls_en), .ls_done(ls_done), .ls_req(ls_req),
    .ls_rdata(ls_rdata), .mem_wr(mem_wr), .mem_a(mem_a), .mem_dout(mem_dout)
  );

  always #2 clk_in = ~clk_in;

  // byte RAM answering the address of the previous cycle
  always begin
    addr_t a;
    @(posedge clk_in);
    a = mem_a;
    if (mem_wr && a < addr_t'(`MEM_RAM_BYTES)) ram[a[16:0]] = mem_dout;
    #1 mem_din = ram[a[16:0]];
  end

  // random pauses of 1 to 5 cycles
  always begin
    @(posedge clk_in);
    #1;
    if (pause_left != 0) begin
      pause_left--;
      if (pause_left == 0) rdy_in = 1'b1;
    end else if (pause_on && rnd(6) == 0) begin
      rdy_in     = 1'b0;
      pause_left = 1 + rnd(5);
    end
  end

  always begin
    @(posedge clk_in);
    #1 io_buffer_full = io_on && (rnd(2) == 1);
  end

  initial begin
    repeat (timeout) @(posedge clk_in);
    $display("run timed out after %0d cycles", timeout);
    $display("TESTBENCH FAILED");
    $finish;
  end

  function automatic int unsigned rnd(input int unsigned n);
    return $urandom % n;
  endfunction

  function automatic int total_errors();
    return scoreboard.errors + tb_errs + uut.chk.err_io + uut.chk.err_rdy
           + uut.chk.err_fv + uut.chk.err_ld;
  endfunction

  function automatic ls_req_t random_ls(input logic wr);
    ls_req_t r;
    int unsigned w;
    w       = rnd(3);
    r.wr    = wr;
    r.width = ls_width_e'(w[1:0]);
    r.addr  = 32'h0001_0000 + rnd(256);  // small window so loads see stores
    r.wdata = $urandom;
    return r;
  endfunction

  // called and returns 1 ns after a rising edge
  task automatic do_fetch(input addr_t a, output int unsigned cyc);
    fetch_addr = a;
    fetch_en   = 1'b1;
    cyc        = 0;
    do begin
      @(negedge clk_in);
      cyc++;
    end while (!fetch_valid);
    @(posedge clk_in);
    #1 fetch_en = 1'b0;
  endtask

  task automatic do_ls(input ls_req_t r, output int unsigned cyc);
    ls_req = r;
    ls_en  = 1'b1;
    cyc    = 0;
    do begin
      @(negedge clk_in);
      cyc++;
    end while (!ls_done);
    @(posedge clk_in);
    #1 ls_en = 1'b0;
  endtask

  task automatic report_test(input int n, input string name);
    $display("test %0d %s finished, errors so far %0d", n, name, total_errors());
  endtask

  initial begin
    int unsigned c1;
    int unsigned c2;
    int unsigned r;
    addr_t       a;
    void'($urandom(1));
    for (int i = 0; i < `MEM_RAM_BYTES; i++) begin
      r = $urandom;
      ram[i[16:0]] = r[7:0];
      scoreboard.shadow[i[16:0]] = r[7:0];
    end
    repeat (8) @(posedge clk_in);
    #1 rst_in = 1'b0;

    for (int i = 0; i < 40; i++) do_fetch(addr_t'(rnd(16384) << 2), c1);
    report_test(1, "random fetch");

    for (int i = 0; i < 20; i++) begin
      a = addr_t'(rnd(16384) << 2);
      do_fetch(a, c1);
      do_fetch(a, c2);
      if (c2 != 2) begin
        $display("fetch hit at %h took %0d cycles instead of one at %0t", a, c2 - 1, $time);
        tb_errs++;
      end
    end
    report_test(2, "fetch hit latency");

    for (int i = 0; i < 30; i++) do_ls(random_ls(1'b1), c1);
    for (int i = 0; i < 30; i++) do_ls(random_ls(1'b0), c1);
    report_test(3, "store then load");

    for (int i = 0; i < 20; i++) begin
      fork
        do_fetch(addr_t'(rnd(16384) << 2), c1);
        do_ls(random_ls(rnd(2) == 1), c2);
      join
      if (c1 > 40 || c2 > 40) begin
        $display("concurrent request too slow at %0t: fetch %0d, load/store %0d cycles",
                 $time, c1, c2);
        tb_errs++;
      end
    end
    report_test(4, "concurrent fetch and load/store");

    pause_on = 1'b1;
    for (int i = 0; i < 20; i++) begin
      fork
        do_fetch(addr_t'(rnd(16384) << 2), c1);
        do_ls(random_ls(rnd(2) == 1), c2);
      join
    end
    pause_on = 1'b0;
    repeat (8) @(posedge clk_in);
    #1;
    report_test(5, "rdy_in pauses");

    io_on = 1'b1;
    for (int i = 0; i < 20; i++) begin
      do_ls(ls_req_t'{wr: 1'b1, width: width_byte, addr: `MEM_IO_ADDR, wdata: $urandom}, c1);
    end
    io_on = 1'b0;
    report_test(6, "UART back-pressure");

    $display("compared %0d values, errors %0d", scoreboard.passes, total_errors());
    if (total_errors() == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hdl
hdl/mem_types_pkg.sv
hdl/mem_req_pkg.sv
hdl/icache.sv
hdl/mem_ctrl.sv
hdl/mem_subsystem.sv
sim/mem_scoreboard.sv
sim/mem_subsystem_chk.sv
sim/tb_mem_subsystem.sv
